//--- logic/glb_bank_pkg.sv
// one bank of 1024 64-bit words with byte strobes; widths are fixed here and not per instance
package glb_bank_pkg;

    // word address into the bank, only the low bits of a global address ever reach us
    localparam int BANK_ADDR_WIDTH = 10;

    // the bank holds every word the address can reach
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

    localparam int BANK_DATA_WIDTH = 64; // one data word per packet

    // one strobe bit covers one byte of the word
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;

    // tag that rides along with a read and comes back in the response
    localparam int PACKET_SEL_WIDTH = 2;

    // what the single memory port does in a given cycle
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0, // port unused
        OP_WRITE = 2'd1, // masked write of data into addr
        OP_READ  = 2'd2  // addr is read and registered at the next edge
    } bank_op_e;

endpackage

//--- logic/bank_cmd_if.sv
// one memory command per cycle from decode, valid in the same cycle; no handshake and no stall
interface bank_cmd_if;
    import glb_bank_pkg::*;

    bank_op_e                   op;         // operation on the port this cycle
    logic [BANK_ADDR_WIDTH-1:0] addr;       // word address for write or read
    logic [BANK_DATA_WIDTH-1:0] data;       // write data, ignored on reads
    logic [BANK_DATA_WIDTH-1:0] bit_sel;    // expanded strobe, one bit per data bit
    logic [PACKET_SEL_WIDTH-1:0] packet_sel; // tag of the read being issued

    // decode builds the whole command
    modport decode (output op, output addr, output data, output bit_sel, output packet_sel);

    // the array only needs the port signals themselves
    modport execute (input op, input addr, input data, input bit_sel);

    // result follows reads and their tags
    modport result (input op, input packet_sel);

endinterface

//--- logic/glb_bank_decode.sv
// a read that meets a write waits one cycle; a read in the cycle right after that is dropped
module glb_bank_decode (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wr_en,
    input  logic [glb_bank_pkg::BANK_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [glb_bank_pkg::BANK_STRB_WIDTH-1:0]  wr_strb,
    input  logic [glb_bank_pkg::BANK_DATA_WIDTH-1:0]  wr_data,
    input  logic                                 rd_en,
    input  logic [glb_bank_pkg::BANK_ADDR_WIDTH-1:0]  rd_addr,
    input  logic [glb_bank_pkg::PACKET_SEL_WIDTH-1:0] rd_packet_sel,
    bank_cmd_if.decode                           cmd
);
    import glb_bank_pkg::*;

    logic                        wr_q_en;    // a write packet was taken at the last edge
    logic [BANK_ADDR_WIDTH-1:0]  wr_q_addr;
    logic [BANK_STRB_WIDTH-1:0]  wr_q_strb;
    logic [BANK_DATA_WIDTH-1:0]  wr_q_data;
    logic                        rd_q_en;    // a read request was taken at the last edge
    logic [BANK_ADDR_WIDTH-1:0]  rd_q_addr;
    logic [PACKET_SEL_WIDTH-1:0] rd_q_sel;
    logic                        pend_valid; // read parked behind a write
    logic [BANK_ADDR_WIDTH-1:0]  pend_addr;
    logic [PACKET_SEL_WIDTH-1:0] pend_sel;
    logic [BANK_DATA_WIDTH-1:0]  wr_bit_sel; // strobe widened to a bit mask

    // enables of the packets taken at the last edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_q_en <= 1'b0;
            rd_q_en <= 1'b0;
        end else begin
            wr_q_en <= wr_en;
            rd_q_en <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        wr_q_addr <= wr_addr; // payload that is valid only alongside its enable
        wr_q_strb <= wr_strb;
        wr_q_data <= wr_data;
        rd_q_addr <= rd_addr;
        rd_q_sel  <= rd_packet_sel;
    end

    // the slot fills on a collision and empties once the port is free of writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (wr_q_en && rd_q_en) begin
            pend_valid <= 1'b1;
        end else if (!wr_q_en) begin
            pend_valid <= 1'b0; // issued this cycle, or it was already empty
        end
    end

    always_ff @(posedge clk) begin
        if (wr_q_en && rd_q_en) begin
            pend_addr <= rd_q_addr; // keep the colliding read until it gets the port
            pend_sel  <= rd_q_sel;
        end
    end

    // each strobe bit covers eight data bits
    always_comb begin
        for (int i = 0; i < BANK_STRB_WIDTH; i++) begin
            wr_bit_sel[i*8 +: 8] = {8{wr_q_strb[i]}};
        end
    end

    // writes win the port, then a parked read, then a fresh read
    always_comb begin
        cmd.op         = OP_IDLE;
        cmd.addr       = rd_q_addr;
        cmd.packet_sel = rd_q_sel;
        if (wr_q_en) begin
            cmd.op   = OP_WRITE;
            cmd.addr = wr_q_addr;
        end else if (pend_valid) begin
            cmd.op         = OP_READ; // a fresh read in this cycle is lost, which the source avoids
            cmd.addr       = pend_addr;
            cmd.packet_sel = pend_sel;
        end else if (rd_q_en) begin
            cmd.op = OP_READ;
        end
    end

    assign cmd.data    = wr_q_data; // don't care on reads
    assign cmd.bit_sel = wr_bit_sel;

endmodule

//--- logic/glb_bank_memory.sv
// contents are undefined after power up and are never cleared; one access per cycle
module glb_bank_memory (
    input  logic                                clk,
    bank_cmd_if.execute                         cmd,
    output logic [glb_bank_pkg::BANK_DATA_WIDTH-1:0] mem_data_out
);
    import glb_bank_pkg::*;

    // single port word array
    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    logic [BANK_DATA_WIDTH-1:0] cur_word;    // word currently at the command address
    logic [BANK_DATA_WIDTH-1:0] merged_word; // old bits kept where bit_sel is clear

    assign cur_word = mem[cmd.addr];

    // bits outside the mask keep their old value
    assign merged_word = (cur_word & ~cmd.bit_sel) | (cmd.data & cmd.bit_sel);

    // the write lands at the next edge, so a read one cycle later already sees it
    always_ff @(posedge clk) begin
        if (cmd.op == OP_WRITE) begin
            mem[cmd.addr] <= merged_word;
        end
    end

    // read data is registered, and it holds between reads
    always_ff @(posedge clk) begin
        if (cmd.op == OP_READ) begin
            mem_data_out <= cur_word;
        end
    end

endmodule

//--- logic/glb_bank_response.sv
// response comes two edges after the command is issued; there is no way to stall it
module glb_bank_response (
    input  logic                                 clk,
    input  logic                                 rst_n,
    bank_cmd_if.result                           cmd,
    input  logic [glb_bank_pkg::BANK_DATA_WIDTH-1:0]  mem_data_out,
    output logic [glb_bank_pkg::BANK_DATA_WIDTH-1:0]  rd_data,
    output logic                                 rd_data_valid,
    output logic [glb_bank_pkg::PACKET_SEL_WIDTH-1:0] rd_data_packet_sel
);
    import glb_bank_pkg::*;

    logic                        rd_pipe;  // a read went into the array at the last edge
    logic [PACKET_SEL_WIDTH-1:0] sel_pipe; // and this was its tag

    // first stage tracks the memory's own read register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pipe <= 1'b0;
        end else begin
            rd_pipe <= (cmd.op == OP_READ);
        end
    end

    always_ff @(posedge clk) begin
        sel_pipe <= cmd.packet_sel; // only used when rd_pipe is set
    end

    // second stage is the response packet itself
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_valid      <= 1'b0;
            rd_data            <= '0;
            rd_data_packet_sel <= '0;
        end else begin
            rd_data_valid <= rd_pipe; // one cycle strobe per read
            if (rd_pipe) begin
                rd_data            <= mem_data_out; // data and tag hold between responses
                rd_data_packet_sel <= sel_pipe;
            end
        end
    end

endmodule

//--- logic/glb_bank.sv
// read latency is two cycles, three after a write collision; no reads the cycle after a collision
module glb_bank (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // write packet
    input  logic                                 wr_en,
    input  logic [glb_bank_pkg::BANK_ADDR_WIDTH-1:0]  wr_addr,
    input  logic [glb_bank_pkg::BANK_STRB_WIDTH-1:0]  wr_strb,
    input  logic [glb_bank_pkg::BANK_DATA_WIDTH-1:0]  wr_data,

    // read request packet
    input  logic                                 rd_en,
    input  logic [glb_bank_pkg::BANK_ADDR_WIDTH-1:0]  rd_addr,
    input  logic [glb_bank_pkg::PACKET_SEL_WIDTH-1:0] rd_packet_sel,

    // read response packet
    output logic [glb_bank_pkg::BANK_DATA_WIDTH-1:0]  rd_data,
    output logic                                 rd_data_valid,
    output logic [glb_bank_pkg::PACKET_SEL_WIDTH-1:0] rd_data_packet_sel
);
    import glb_bank_pkg::*;

    logic [BANK_DATA_WIDTH-1:0] mem_data_out; // registered read word from the array

    // command bus shared by decode, memory and response
    bank_cmd_if cmd_if ();

    // decode turns packets into one port command per cycle
    glb_bank_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_strb       (wr_strb),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_packet_sel (rd_packet_sel),
        .cmd           (cmd_if)
    );

    glb_bank_memory u_memory (
        .clk          (clk),
        .cmd          (cmd_if),
        .mem_data_out (mem_data_out)
    );

    // the response stage lines the tag up with the read word
    glb_bank_response u_response (
        .clk                (clk),
        .rst_n              (rst_n),
        .cmd                (cmd_if),
        .mem_data_out       (mem_data_out),
        .rd_data            (rd_data),
        .rd_data_valid      (rd_data_valid),
        .rd_data_packet_sel (rd_data_packet_sel)
    );

endmodule

//--- tb/glb_bank_checker.sv
// protocol rules seen at the bank's own ports only; assumes one read is counted per rd_en
module glb_bank_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_en,
    input  logic rd_en,
    input  logic rd_data_valid
);

    int outstanding; // reads accepted and not yet answered

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(rd_en) - int'(rd_data_valid);
        end
    end

    // the pending slot is busy for one cycle after a collision
    property read_gap_after_collision;
        @(posedge clk) disable iff (!rst_n) (wr_en && rd_en) |=> !rd_en;
    endproperty

    collision_gap_a: assert property (read_gap_after_collision)
        else $error("read request in the cycle right after a write and read collision");

    // two responses in a row need reads that are still waiting
    valid_pair_a: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_data_valid && $past(rd_data_valid)) |-> (outstanding > 0))
        else $error("rd_data_valid high twice in a row with no read outstanding");

    // reset clears the response strobe at the next edge
    reset_quiet_a: assert property (@(posedge clk) !rst_n |=> !rd_data_valid)
        else $error("rd_data_valid high while the bank is held in reset");

endmodule

bind glb_bank glb_bank_checker chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_en         (wr_en),
    .rd_en         (rd_en),
    .rd_data_valid (rd_data_valid)
);

//--- tb/glb_bank_tb.sv
// stimulus keeps the cycle after a collision idle and reads only words it has fully written
module glb_bank_tb;
    import glb_bank_pkg::*;

    // one table row is one cycle of input and lat is its expected read latency in cycles
    typedef struct packed {
        logic                        wr_en;
        logic [BANK_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_STRB_WIDTH-1:0]  wr_strb;
        logic [BANK_DATA_WIDTH-1:0]  wr_data;
        logic                        rd_en;
        logic [BANK_ADDR_WIDTH-1:0]  rd_addr;
        logic [PACKET_SEL_WIDTH-1:0] rd_sel;
        int                          lat;
    } entry_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0]  data;
        logic [PACKET_SEL_WIDTH-1:0] sel;
        int                          cycle; // edge count at which the response must show
    } resp_t;

    logic                        clk;
    logic                        rst_n;
    logic                        wr_en;
    logic [BANK_ADDR_WIDTH-1:0]  wr_addr;
    logic [BANK_STRB_WIDTH-1:0]  wr_strb;
    logic [BANK_DATA_WIDTH-1:0]  wr_data;
    logic                        rd_en;
    logic [BANK_ADDR_WIDTH-1:0]  rd_addr;
    logic [PACKET_SEL_WIDTH-1:0] rd_packet_sel;
    logic [BANK_DATA_WIDTH-1:0]  rd_data;
    logic                        rd_data_valid;
    logic [PACKET_SEL_WIDTH-1:0] rd_data_packet_sel;

    entry_t                     steps[$];          // the stimulus table
    resp_t                      exp_q[$];          // responses still owed by the bank
    logic [BANK_DATA_WIDTH-1:0] shadow [BANK_DEPTH]; // reference copy of the array
    integer                     seed;
    int                         cycle_cnt = 0;     // rising edges seen so far

    glb_bank uut (
        .clk                (clk),
        .rst_n              (rst_n),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_strb            (wr_strb),
        .wr_data            (wr_data),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .rd_packet_sel      (rd_packet_sel),
        .rd_data            (rd_data),
        .rd_data_valid      (rd_data_valid),
        .rd_data_packet_sel (rd_data_packet_sel)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [BANK_DATA_WIDTH-1:0] actual,
                               input logic [BANK_DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t, %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // appends one row whose write data comes from the seeded generator
    task automatic add_step(input logic we, input logic [BANK_ADDR_WIDTH-1:0] wa,
                            input logic [BANK_STRB_WIDTH-1:0] ws, input logic re,
                            input logic [BANK_ADDR_WIDTH-1:0] ra,
                            input logic [PACKET_SEL_WIDTH-1:0] rs, input int lat);
        entry_t e;
        e.wr_en   = we;
        e.wr_addr = wa;
        e.wr_strb = ws;
        e.wr_data = we ? {$random(seed), $random(seed)} : '0;
        e.rd_en   = re;
        e.rd_addr = ra;
        e.rd_sel  = rs;
        e.lat     = lat;
        steps.push_back(e);
    endtask

    task automatic build_table();
        // quiet cycles after reset where nothing may come back
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        // full words and then a single read that returns its word two cycles later
        add_step(1'b1, 10'h010, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h011, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h012, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h013, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h010, 2'd1, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        // back to back reads keep several in flight
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h011, 2'd3, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h012, 2'd2, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h013, 2'd0, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h010, 2'd1, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        // partial strobes merge with the old bytes
        add_step(1'b1, 10'h100, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h2a5, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h3ff, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h100, 8'h0f, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h2a5, 8'ha5, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h3ff, 8'h80, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h100, 8'h00, 1'b1, 10'h3ff, 2'd3, 3); // empty strobe changes nothing
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h100, 2'd2, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h2a5, 2'd1, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        // collision on one address where the parked read reaches the port after the write
        add_step(1'b1, 10'h040, 8'hff, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b1, 10'h040, 8'h3c, 1'b1, 10'h040, 2'd2, 3);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h040, 2'd0, 2);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        // collision on two addresses and a read that answers right behind it
        add_step(1'b1, 10'h041, 8'hff, 1'b1, 10'h012, 2'd1, 3);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h041, 2'd3, 2);
        add_step(1'b1, 10'h012, 8'hf0, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b1, 10'h012, 2'd0, 2);
        // idle tail whose last row stays on the inputs
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
        add_step(1'b0, 10'h000, 8'h00, 1'b0, 10'h000, 2'd0, 0);
    endtask

    // outputs are stable at the falling edge, so this is where they are sampled
    task automatic check_outputs();
        resp_t want;
        if (rd_data_valid) begin
            if (exp_q.size() == 0) begin
                $display("read response at time %0t while no read was outstanding", $time);
                stop_with_failure();
            end else begin
                want = exp_q.pop_front();
                check_value("response cycle", 64'(cycle_cnt), 64'(want.cycle));
                check_value("rd_data", rd_data, want.data);
                check_value("rd_data_packet_sel", 64'(rd_data_packet_sel), 64'(want.sel));
            end
        end else if (exp_q.size() != 0 && exp_q[0].cycle <= cycle_cnt) begin
            $display("read response due at edge %0d never arrived (time %0t)",
                     exp_q[0].cycle, $time);
            stop_with_failure();
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    // drives one row and updates the reference with the write ahead of the read as on the port
    task automatic drive_step(input entry_t e);
        logic [BANK_DATA_WIDTH-1:0] word;
        resp_t                      want;
        wr_en         = e.wr_en;
        wr_addr       = e.wr_addr;
        wr_strb       = e.wr_strb;
        wr_data       = e.wr_data;
        rd_en         = e.rd_en;
        rd_addr       = e.rd_addr;
        rd_packet_sel = e.rd_sel;
        if (e.wr_en) begin
            word = shadow[e.wr_addr];
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (e.wr_strb[b]) word[b*8 +: 8] = e.wr_data[b*8 +: 8]; // byte by byte
            end
            shadow[e.wr_addr] = word;
        end
        if (e.rd_en) begin
            want.data  = shadow[e.rd_addr];
            want.sel   = e.rd_sel;
            want.cycle = cycle_cnt + 1 + e.lat; // request is taken at the next edge
            exp_q.push_back(want);
        end
    endtask

    initial begin
        int wait_cnt;
        seed          = 26;
        rst_n         = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_strb       = '0;
        wr_data       = '0;
        rd_en         = 1'b0;
        rd_addr       = '0;
        rd_packet_sel = '0;
        build_table();
        repeat (16) @(negedge clk);
        // the response port comes out of reset cleared
        check_value("rd_data_valid", 64'(rd_data_valid), 64'(0));
        check_value("rd_data", rd_data, '0);
        check_value("rd_data_packet_sel", 64'(rd_data_packet_sel), 64'(0));
        rst_n = 1'b1;
        foreach (steps[i]) begin
            step_cycle();
            drive_step(steps[i]);
        end
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 20) begin // drain with a bound
            step_cycle();
            wait_cnt++;
        end
        repeat (4) step_cycle(); // idle bank must stay silent
        if (exp_q.size() != 0) begin
            $display("timeout with %0d reads still waiting for a response", exp_q.size());
            stop_with_failure();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
logic/glb_bank_pkg.sv
logic/bank_cmd_if.sv
logic/glb_bank_decode.sv
logic/glb_bank_memory.sv
logic/glb_bank_response.sv
logic/glb_bank.sv
tb/glb_bank_checker.sv
tb/glb_bank_tb.sv

//--- Makefile
# a failing run ends in $fatal, so make sees the simulator's nonzero exit status

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module glb_bank_tb \
		-f filelist.f -o glb_bank_sim
	./obj_dir/glb_bank_sim

clean:
	rm -rf obj_dir
